/* test/golden_vectors.txt */
# addr msg size subop data reply | exp op net_addr x y payload mask | exp resp data
# all hex, my_y is 05 so host packets go to y 04
c018200400 0 2 0 00000000 deadbeef 0 0000100 02 03 00000000 0 deadbeef
c018200402 0 1 0 00000000 12345678 0 0000100 02 03 00000006 0 56785678
c018200403 0 0 0 00000000 000000a5 0 0000100 02 03 0000000b 0 a5a5a5a5
c018200401 2 0 0 00000000 11223344 0 0000100 02 03 00000009 0 44444444
c018200410 1 2 0 cafef00d 00000000 1 0000104 02 03 cafef00d f 00000000
c018200412 3 1 0 0000beef 0000ffff 1 0000104 02 03 0000beef c ffffffff
c018200413 1 0 0 000000aa 00000001 1 0000104 02 03 000000aa 8 01010101
814048d158 4 2 0 00000005 00000010 6 0123456 05 00 00000005 0 00000010
a14048d158 4 2 1 0000f000 00000abc 5 0123456 05 7f 0000f000 0 00000abc
a14048d158 4 2 2 12121212 34343434 4 0123456 05 7f 12121212 0 34343434
0000123458 0 2 0 00000000 0badf00d 0 0123458 00 04 00000000 0 0badf00d
4abcdef004 1 1 0 00005a5a 00001234 1 cdef004 00 04 00005a5a 3 12341234
c018200400 0 1 0 00000000 abcd9876 0 0000100 02 03 00000004 0 98769876
c018200400 1 0 0 00000077 00000000 1 0000100 02 03 00000077 1 00000000
0000000002 2 0 0 00000000 000000c3 0 0000002 00 04 0000000a 0 c3c3c3c3
c3fff00000 1 1 0 0000abcd 00000002 1 0000000 7f 7f 0000abcd 3 00020002

/* tb.f */
+incdir+test
rtl/mc_bridge_pkg.sv
rtl/cmd_fifo.sv
rtl/request_former.sv
rtl/reorder_buffer.sv
rtl/response_former.sv
rtl/mc_bridge.sv
test/tb_mc_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the bridge testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_mc_bridge -o sim_mc_bridge > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_mc_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* test/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one field of a packet or response against its expected value
task automatic report_value(string name, string field, string exp_s, string act_s);
  $display("ERROR %s %s expected %s actual %s", name, field, exp_s, act_s);
  stop_with_failure("a value did not match its expected value");
endtask

task automatic check_packet(string name,
                            net_op_e exp_op, net_op_e act_op,
                            logic [NET_ADDR_WIDTH-1:0] exp_addr,
                            logic [NET_ADDR_WIDTH-1:0] act_addr,
                            logic [X_CORD_WIDTH-1:0] exp_x, logic [X_CORD_WIDTH-1:0] act_x,
                            logic [Y_CORD_WIDTH-1:0] exp_y, logic [Y_CORD_WIDTH-1:0] act_y,
                            logic [DATA_WIDTH-1:0] exp_payload,
                            logic [DATA_WIDTH-1:0] act_payload,
                            logic [MASK_WIDTH-1:0] exp_mask, logic [MASK_WIDTH-1:0] act_mask);
  if (exp_op != act_op)
    report_value(name, "op", exp_op.name(), act_op.name());
  if (exp_addr != act_addr)
    report_value(name, "addr", $sformatf("%h", exp_addr), $sformatf("%h", act_addr));
  if (exp_x != act_x)
    report_value(name, "x", $sformatf("%h", exp_x), $sformatf("%h", act_x));
  if (exp_y != act_y)
    report_value(name, "y", $sformatf("%h", exp_y), $sformatf("%h", act_y));
  if (exp_payload != act_payload)
    report_value(name, "payload", $sformatf("%h", exp_payload), $sformatf("%h", act_payload));
  if (exp_mask != act_mask)
    report_value(name, "mask", $sformatf("%h", exp_mask), $sformatf("%h", act_mask));
endtask

task automatic check_resp(string name,
                          logic [PADDR_WIDTH-1:0] exp_addr, logic [PADDR_WIDTH-1:0] act_addr,
                          mem_msg_e exp_msg, mem_msg_e act_msg,
                          msg_size_e exp_size, msg_size_e act_size,
                          logic [DATA_WIDTH-1:0] exp_data, logic [DATA_WIDTH-1:0] act_data);
  if (exp_addr != act_addr)
    report_value(name, "resp addr", $sformatf("%h", exp_addr), $sformatf("%h", act_addr));
  if (exp_msg != act_msg)
    report_value(name, "resp msg", exp_msg.name(), act_msg.name());
  if (exp_size != act_size)
    report_value(name, "resp size", exp_size.name(), act_size.name());
  if (exp_data != act_data)
    report_value(name, "resp data", $sformatf("%h", exp_data), $sformatf("%h", act_data));
endtask

`endif

/* test/tb_mc_bridge.sv */
`timescale 1ns/1ps

module tb_mc_bridge
  import mc_bridge_pkg::*;
  ();

  localparam int MAX_VECTORS = 64;
  localparam logic [Y_CORD_WIDTH-1:0] MY_Y = 7'h05;

  logic clk_i, reset_i;
  logic [Y_CORD_WIDTH-1:0] my_y_i;
  logic [PADDR_WIDTH-1:0] io_cmd_addr_i;
  mem_msg_e io_cmd_msg_i;
  msg_size_e io_cmd_size_i;
  amo_subop_e io_cmd_subop_i;
  logic [DATA_WIDTH-1:0] io_cmd_data_i;
  logic io_cmd_v_i, io_cmd_ready_o;
  logic [NET_ADDR_WIDTH-1:0] out_addr_o;
  net_op_e out_op_o;
  logic [REG_ID_WIDTH-1:0] out_reg_id_o;
  logic [DATA_WIDTH-1:0] out_payload_o;
  logic [MASK_WIDTH-1:0] out_mask_o;
  logic [X_CORD_WIDTH-1:0] out_x_o;
  logic [Y_CORD_WIDTH-1:0] out_y_o;
  logic out_v_o, out_ready_i;
  logic returned_v_i;
  logic [REG_ID_WIDTH-1:0] returned_reg_id_i;
  logic [DATA_WIDTH-1:0] returned_data_i;
  logic [PADDR_WIDTH-1:0] io_resp_addr_o;
  mem_msg_e io_resp_msg_o;
  msg_size_e io_resp_size_o;
  logic [DATA_WIDTH-1:0] io_resp_data_o;
  logic io_resp_v_o, io_resp_yumi_i;

  // vector table with one transaction per entry
  logic [PADDR_WIDTH-1:0] v_addr [MAX_VECTORS];
  logic [2:0] v_msg [MAX_VECTORS];
  logic [1:0] v_size [MAX_VECTORS];
  logic [1:0] v_subop [MAX_VECTORS];
  logic [DATA_WIDTH-1:0] v_data [MAX_VECTORS];
  logic [DATA_WIDTH-1:0] v_reply [MAX_VECTORS];
  logic [2:0] v_op [MAX_VECTORS];
  logic [NET_ADDR_WIDTH-1:0] v_naddr [MAX_VECTORS];
  logic [X_CORD_WIDTH-1:0] v_x [MAX_VECTORS];
  logic [Y_CORD_WIDTH-1:0] v_y [MAX_VECTORS];
  logic [DATA_WIDTH-1:0] v_payload [MAX_VECTORS];
  logic [MASK_WIDTH-1:0] v_mask [MAX_VECTORS];
  logic [DATA_WIDTH-1:0] v_resp [MAX_VECTORS];
  int num_vectors;

  // packets in flight in the network model
  int pend_id [$];
  logic [DATA_WIDTH-1:0] pend_data [$];
  int pend_due [$];

  mc_bridge dut
    (.clk_i(clk_i), .reset_i(reset_i), .my_y_i(my_y_i)
     ,.io_cmd_addr_i(io_cmd_addr_i), .io_cmd_msg_i(io_cmd_msg_i)
     ,.io_cmd_size_i(io_cmd_size_i), .io_cmd_subop_i(io_cmd_subop_i)
     ,.io_cmd_data_i(io_cmd_data_i), .io_cmd_v_i(io_cmd_v_i)
     ,.io_cmd_ready_o(io_cmd_ready_o)
     ,.out_addr_o(out_addr_o), .out_op_o(out_op_o), .out_reg_id_o(out_reg_id_o)
     ,.out_payload_o(out_payload_o), .out_mask_o(out_mask_o)
     ,.out_x_o(out_x_o), .out_y_o(out_y_o), .out_v_o(out_v_o), .out_ready_i(out_ready_i)
     ,.returned_v_i(returned_v_i), .returned_reg_id_i(returned_reg_id_i)
     ,.returned_data_i(returned_data_i)
     ,.io_resp_addr_o(io_resp_addr_o), .io_resp_msg_o(io_resp_msg_o)
     ,.io_resp_size_o(io_resp_size_o), .io_resp_data_o(io_resp_data_o)
     ,.io_resp_v_o(io_resp_v_o), .io_resp_yumi_i(io_resp_yumi_i)
     );

  always #2 clk_i = ~clk_i;

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // vector file
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int fd;
    int cnt;
    string line;
    logic [PADDR_WIDTH-1:0] t [13];
    fd = $fopen("test/golden_vectors.txt", "r");
    if (fd == 0)
      stop_with_failure("could not open test/golden_vectors.txt");
    num_vectors = 0;
    while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line.substr(0, 0) != "#")
          begin
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", t[0], t[1], t[2],
                          t[3], t[4], t[5], t[6], t[7], t[8], t[9], t[10], t[11], t[12]);
            if (cnt != 13)
              stop_with_failure("malformed line in the vector file");
            v_addr[num_vectors]    = t[0];
            v_msg[num_vectors]     = t[1][2:0];
            v_size[num_vectors]    = t[2][1:0];
            v_subop[num_vectors]   = t[3][1:0];
            v_data[num_vectors]    = t[4][DATA_WIDTH-1:0];
            v_reply[num_vectors]   = t[5][DATA_WIDTH-1:0];
            v_op[num_vectors]      = t[6][2:0];
            v_naddr[num_vectors]   = t[7][NET_ADDR_WIDTH-1:0];
            v_x[num_vectors]       = t[8][X_CORD_WIDTH-1:0];
            v_y[num_vectors]       = t[9][Y_CORD_WIDTH-1:0];
            v_payload[num_vectors] = t[10][DATA_WIDTH-1:0];
            v_mask[num_vectors]    = t[11][MASK_WIDTH-1:0];
            v_resp[num_vectors]    = t[12][DATA_WIDTH-1:0];
            num_vectors++;
          end
      end
    $fclose(fd);
    if (num_vectors == 0)
      stop_with_failure("the vector file holds no transactions");
  endtask

  task automatic drive_command(int idx);
    if (idx < num_vectors)
      begin
        io_cmd_v_i     <= 1'b1;
        io_cmd_addr_i  <= v_addr[idx];
        io_cmd_msg_i   <= mem_msg_e'(v_msg[idx]);
        io_cmd_size_i  <= msg_size_e'(v_size[idx]);
        io_cmd_subop_i <= amo_subop_e'(v_subop[idx]);
        io_cmd_data_i  <= v_data[idx];
      end
    else
      io_cmd_v_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main loop
  ////////////////////////////////////////////////////////////////////////////

  initial
    begin
      int cycle, limit, cmd_idx, pkt_idx, resp_idx, sel;
      logic stall, took;
      void'($urandom(15));
      clk_i = 1'b0;
      reset_i = 1'b1;
      my_y_i = MY_Y;
      io_cmd_v_i = 1'b0;
      io_cmd_addr_i = '0;
      io_cmd_msg_i = e_mem_rd;
      io_cmd_size_i = e_size_4;
      io_cmd_subop_i = e_amoadd;
      io_cmd_data_i = '0;
      out_ready_i = 1'b0;
      returned_v_i = 1'b0;
      returned_reg_id_i = '0;
      returned_data_i = '0;
      io_resp_yumi_i = 1'b0;
      load_vectors();
      limit = 60 * num_vectors + 200;
      cycle = 0;
      cmd_idx = 0;
      pkt_idx = 0;
      resp_idx = 0;
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;
      drive_command(0);
      while (resp_idx < num_vectors)
        begin
          @(posedge clk_i);
          cycle++;
          if (cycle > limit)
            stop_with_failure("timeout, not every response arrived in time");
          // a window with the network stalled and responses withheld
          stall = (cycle >= 40 && cycle < 80);

          if (io_cmd_v_i && io_cmd_ready_o)
            cmd_idx++;
          drive_command(cmd_idx);

          if (out_v_o)
            begin
              if (!out_ready_i)
                stop_with_failure("a packet was sent while the network was not ready");
              if (pkt_idx >= num_vectors)
                stop_with_failure("more packets were sent than commands were given");
              if (int'(out_reg_id_o) >= MAX_OUTSTANDING)
                stop_with_failure("a packet carried a register id outside the tracked range");
              foreach (pend_id[i])
                if (pend_id[i] == int'(out_reg_id_o))
                  stop_with_failure("a register id was reused while still in flight");
              check_packet($sformatf("vector %0d", pkt_idx),
                           net_op_e'(v_op[pkt_idx]), out_op_o, v_naddr[pkt_idx], out_addr_o,
                           v_x[pkt_idx], out_x_o, v_y[pkt_idx], out_y_o,
                           v_payload[pkt_idx], out_payload_o, v_mask[pkt_idx], out_mask_o);
              pend_id.push_back(int'(out_reg_id_o));
              pend_data.push_back(v_reply[pkt_idx]);
              pend_due.push_back(cycle + int'($urandom_range(1, 12)));
              pkt_idx++;
            end
          out_ready_i <= !stall && ($urandom_range(0, 3) != 0);

          // oldest reply whose delay has run out
          sel = -1;
          foreach (pend_due[i])
            if (sel < 0 && pend_due[i] <= cycle)
              sel = i;
          if (sel >= 0)
            begin
              returned_v_i      <= 1'b1;
              returned_reg_id_i <= REG_ID_WIDTH'(pend_id[sel]);
              returned_data_i   <= pend_data[sel];
              pend_id.delete(sel);
              pend_data.delete(sel);
              pend_due.delete(sel);
            end
          else
            returned_v_i <= 1'b0;

          if (io_resp_yumi_i && !io_resp_v_o)
            stop_with_failure("a response dropped its valid before it was taken");
          took = io_resp_v_o && io_resp_yumi_i;
          if (took)
            begin
              check_resp($sformatf("vector %0d", resp_idx),
                         v_addr[resp_idx], io_resp_addr_o, mem_msg_e'(v_msg[resp_idx]),
                         io_resp_msg_o, msg_size_e'(v_size[resp_idx]), io_resp_size_o,
                         v_resp[resp_idx], io_resp_data_o);
              resp_idx++;
            end
          // only a response that stays valid may be taken next cycle
          io_resp_yumi_i <= io_resp_v_o && !took && !stall && ($urandom_range(0, 2) != 0);
        end
      $display("TEST OK");
      $finish;
    end

endmodule

/* rtl/mc_bridge.sv */
`timescale 1ns/1ps

module mc_bridge
  import mc_bridge_pkg::*;
  (input                               clk_i
   , input                             reset_i
   , input [Y_CORD_WIDTH-1:0]          my_y_i

   // processor commands
   , input [PADDR_WIDTH-1:0]           io_cmd_addr_i
   , input mem_msg_e                   io_cmd_msg_i
   , input msg_size_e                  io_cmd_size_i
   , input amo_subop_e                 io_cmd_subop_i
   , input [DATA_WIDTH-1:0]            io_cmd_data_i
   , input                             io_cmd_v_i
   , output logic                      io_cmd_ready_o

   // requests into the mesh
   , output logic [NET_ADDR_WIDTH-1:0] out_addr_o
   , output net_op_e                   out_op_o
   , output logic [REG_ID_WIDTH-1:0]   out_reg_id_o
   , output logic [DATA_WIDTH-1:0]     out_payload_o
   , output logic [MASK_WIDTH-1:0]     out_mask_o
   , output logic [X_CORD_WIDTH-1:0]   out_x_o
   , output logic [Y_CORD_WIDTH-1:0]   out_y_o
   , output logic                      out_v_o
   , input                             out_ready_i

   // replies from the mesh are always taken
   , input                             returned_v_i
   , input [REG_ID_WIDTH-1:0]          returned_reg_id_i
   , input [DATA_WIDTH-1:0]            returned_data_i

   // processor responses
   , output logic [PADDR_WIDTH-1:0]    io_resp_addr_o
   , output mem_msg_e                  io_resp_msg_o
   , output msg_size_e                 io_resp_size_o
   , output logic [DATA_WIDTH-1:0]     io_resp_data_o
   , output logic                      io_resp_v_o
   , input                             io_resp_yumi_i
   );

  logic [PADDR_WIDTH-1:0]    head_addr_lo;
  mem_msg_e                  head_msg_lo;
  msg_size_e                 head_size_lo;
  amo_subop_e                head_subop_lo;
  logic [DATA_WIDTH-1:0]     head_data_lo;
  logic                      head_v_lo, head_pop_lo;

  logic                      alloc_lo, alloc_v_lo;
  logic [TRANS_ID_WIDTH-1:0] alloc_id_lo;

  logic [PADDR_WIDTH-1:0]    deq_addr_lo;
  mem_msg_e                  deq_msg_lo;
  msg_size_e                 deq_size_lo;
  logic [DATA_WIDTH-1:0]     deq_data_lo;
  logic                      deq_v_lo, deq_lo;

  ////////////////////////////////////////////////////////////////////////////
  // command side
  ////////////////////////////////////////////////////////////////////////////

  cmd_fifo cmd_queue
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.wr_addr_i(io_cmd_addr_i)
     ,.wr_msg_i(io_cmd_msg_i)
     ,.wr_size_i(io_cmd_size_i)
     ,.wr_subop_i(io_cmd_subop_i)
     ,.wr_data_i(io_cmd_data_i)
     ,.wr_v_i(io_cmd_v_i)
     ,.wr_ready_o(io_cmd_ready_o)
     ,.head_addr_o(head_addr_lo)
     ,.head_msg_o(head_msg_lo)
     ,.head_size_o(head_size_lo)
     ,.head_subop_o(head_subop_lo)
     ,.head_data_o(head_data_lo)
     ,.head_v_o(head_v_lo)
     ,.pop_i(head_pop_lo)
     );

  request_former req_former
    (.cmd_addr_i(head_addr_lo)
     ,.cmd_msg_i(head_msg_lo)
     ,.cmd_size_i(head_size_lo)
     ,.cmd_subop_i(head_subop_lo)
     ,.cmd_data_i(head_data_lo)
     ,.cmd_v_i(head_v_lo)
     ,.cmd_pop_o(head_pop_lo)
     ,.alloc_id_i(alloc_id_lo)
     ,.alloc_v_i(alloc_v_lo)
     ,.alloc_o(alloc_lo)
     ,.my_y_i(my_y_i)
     ,.out_addr_o(out_addr_o)
     ,.out_op_o(out_op_o)
     ,.out_reg_id_o(out_reg_id_o)
     ,.out_payload_o(out_payload_o)
     ,.out_mask_o(out_mask_o)
     ,.out_x_o(out_x_o)
     ,.out_y_o(out_y_o)
     ,.out_v_o(out_v_o)
     ,.out_ready_i(out_ready_i)
     );

  ////////////////////////////////////////////////////////////////////////////
  // tracking and response side
  ////////////////////////////////////////////////////////////////////////////

  reorder_buffer rob
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.alloc_i(alloc_lo)
     ,.alloc_addr_i(head_addr_lo)
     ,.alloc_msg_i(head_msg_lo)
     ,.alloc_size_i(head_size_lo)
     ,.alloc_id_o(alloc_id_lo)
     ,.alloc_v_o(alloc_v_lo)
     ,.returned_v_i(returned_v_i)
     ,.returned_reg_id_i(returned_reg_id_i)
     ,.returned_data_i(returned_data_i)
     ,.deq_addr_o(deq_addr_lo)
     ,.deq_msg_o(deq_msg_lo)
     ,.deq_size_o(deq_size_lo)
     ,.deq_data_o(deq_data_lo)
     ,.deq_v_o(deq_v_lo)
     ,.deq_i(deq_lo)
     );

  response_former resp_former
    (.deq_addr_i(deq_addr_lo)
     ,.deq_msg_i(deq_msg_lo)
     ,.deq_size_i(deq_size_lo)
     ,.deq_data_i(deq_data_lo)
     ,.deq_v_i(deq_v_lo)
     ,.deq_o(deq_lo)
     ,.io_resp_addr_o(io_resp_addr_o)
     ,.io_resp_msg_o(io_resp_msg_o)
     ,.io_resp_size_o(io_resp_size_o)
     ,.io_resp_data_o(io_resp_data_o)
     ,.io_resp_v_o(io_resp_v_o)
     ,.io_resp_yumi_i(io_resp_yumi_i)
     );

endmodule

/* rtl/response_former.sv */
`timescale 1ns/1ps

module response_former
  import mc_bridge_pkg::*;
  (input [PADDR_WIDTH-1:0]             deq_addr_i
   , input mem_msg_e                   deq_msg_i
   , input msg_size_e                  deq_size_i
   , input [DATA_WIDTH-1:0]            deq_data_i
   , input                             deq_v_i
   , output logic                      deq_o

   , output logic [PADDR_WIDTH-1:0]    io_resp_addr_o
   , output mem_msg_e                  io_resp_msg_o
   , output msg_size_e                 io_resp_size_o
   , output logic [DATA_WIDTH-1:0]     io_resp_data_o
   , output logic                      io_resp_v_o
   , input                             io_resp_yumi_i
   );

  // header comes back unchanged
  assign io_resp_addr_o = deq_addr_i;
  assign io_resp_msg_o  = deq_msg_i;
  assign io_resp_size_o = deq_size_i;

  // fill the whole word with the accessed bytes
  always_comb
    begin
      case (deq_size_i)
        e_size_1: io_resp_data_o = {4{deq_data_i[7:0]}};
        e_size_2: io_resp_data_o = {2{deq_data_i[15:0]}};
        default:  io_resp_data_o = deq_data_i;
      endcase
    end

  assign io_resp_v_o = deq_v_i;

  // release the entry once the processor takes it
  assign deq_o = io_resp_v_o & io_resp_yumi_i;

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer
  import mc_bridge_pkg::*;
  (input                               clk_i
   , input                             reset_i

   , input                             alloc_i
   , input [PADDR_WIDTH-1:0]           alloc_addr_i
   , input mem_msg_e                   alloc_msg_i
   , input msg_size_e                  alloc_size_i
   , output logic [TRANS_ID_WIDTH-1:0] alloc_id_o
   , output logic                      alloc_v_o

   , input                             returned_v_i
   , input [REG_ID_WIDTH-1:0]          returned_reg_id_i
   , input [DATA_WIDTH-1:0]            returned_data_i

   , output logic [PADDR_WIDTH-1:0]    deq_addr_o
   , output mem_msg_e                  deq_msg_o
   , output msg_size_e                 deq_size_o
   , output logic [DATA_WIDTH-1:0]     deq_data_o
   , output logic                      deq_v_o
   , input                             deq_i
   );

  logic [PADDR_WIDTH-1:0] addr_mem [MAX_OUTSTANDING];
  mem_msg_e               msg_mem  [MAX_OUTSTANDING];
  msg_size_e              size_mem [MAX_OUTSTANDING];
  logic [DATA_WIDTH-1:0]  data_mem [MAX_OUTSTANDING];

  logic [MAX_OUTSTANDING-1:0] filled_r;
  logic [TRANS_ID_WIDTH-1:0]  alloc_ptr_r, deq_ptr_r;
  logic [TRANS_ID_WIDTH:0]    used_r;

  logic                      write_v;
  logic [TRANS_ID_WIDTH-1:0] write_id;

  ////////////////////////////////////////////////////////////////////////////
  // allocate and write back
  ////////////////////////////////////////////////////////////////////////////

  assign alloc_id_o = alloc_ptr_r;
  assign alloc_v_o  = (used_r != (TRANS_ID_WIDTH+1)'(MAX_OUTSTANDING));

  // replies with ids outside the tracked range are dropped
  assign write_v  = returned_v_i & (returned_reg_id_i < REG_ID_WIDTH'(MAX_OUTSTANDING));
  assign write_id = returned_reg_id_i[TRANS_ID_WIDTH-1:0];

  always_ff @(posedge clk_i)
    begin
      if (alloc_i)
        begin
          addr_mem[alloc_ptr_r] <= alloc_addr_i;
          msg_mem[alloc_ptr_r]  <= alloc_msg_i;
          size_mem[alloc_ptr_r] <= alloc_size_i;
        end
      if (write_v)
        data_mem[write_id] <= returned_data_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          filled_r    <= '0;
          alloc_ptr_r <= '0;
          deq_ptr_r   <= '0;
          used_r      <= '0;
        end
      else
        begin
          if (alloc_i)
            alloc_ptr_r <= alloc_ptr_r + TRANS_ID_WIDTH'(1);
          if (deq_i)
            begin
              deq_ptr_r           <= deq_ptr_r + TRANS_ID_WIDTH'(1);
              filled_r[deq_ptr_r] <= 1'b0;
            end
          if (write_v)
            filled_r[write_id] <= 1'b1;
          case ({alloc_i, deq_i})
            2'b10:   used_r <= used_r + (TRANS_ID_WIDTH+1)'(1);
            2'b01:   used_r <= used_r - (TRANS_ID_WIDTH+1)'(1);
            default: used_r <= used_r;
          endcase
        end
    end

  ////////////////////////////////////////////////////////////////////////////
  // in-order release
  ////////////////////////////////////////////////////////////////////////////

  assign deq_v_o    = (used_r != '0) & filled_r[deq_ptr_r];
  assign deq_addr_o = addr_mem[deq_ptr_r];
  assign deq_msg_o  = msg_mem[deq_ptr_r];
  assign deq_size_o = size_mem[deq_ptr_r];
  assign deq_data_o = data_mem[deq_ptr_r];

endmodule

/* rtl/request_former.sv */
`timescale 1ns/1ps

module request_former
  import mc_bridge_pkg::*;
  (input [PADDR_WIDTH-1:0]             cmd_addr_i
   , input mem_msg_e                   cmd_msg_i
   , input msg_size_e                  cmd_size_i
   , input amo_subop_e                 cmd_subop_i
   , input [DATA_WIDTH-1:0]            cmd_data_i
   , input                             cmd_v_i
   , output logic                      cmd_pop_o

   , input [TRANS_ID_WIDTH-1:0]        alloc_id_i
   , input                             alloc_v_i
   , output logic                      alloc_o

   , input [Y_CORD_WIDTH-1:0]          my_y_i

   , output logic [NET_ADDR_WIDTH-1:0] out_addr_o
   , output net_op_e                   out_op_o
   , output logic [REG_ID_WIDTH-1:0]   out_reg_id_o
   , output logic [DATA_WIDTH-1:0]     out_payload_o
   , output logic [MASK_WIDTH-1:0]     out_mask_o
   , output logic [X_CORD_WIDTH-1:0]   out_x_o
   , output logic [Y_CORD_WIDTH-1:0]   out_y_o
   , output logic                      out_v_o
   , input                             out_ready_i
   );

  ////////////////////////////////////////////////////////////////////////////
  // target decode
  ////////////////////////////////////////////////////////////////////////////

  logic [1:0] target;
  logic       is_tile, is_vcache;
  logic       vcache_top_row;

  assign target    = cmd_addr_i[PADDR_WIDTH-1-:2];
  assign is_tile   = (target == TARGET_TILE);
  assign is_vcache = (target == TARGET_VCACHE);

  // one address bit picks the top or bottom cache row
  assign vcache_top_row = cmd_addr_i[2+NET_ADDR_WIDTH+X_CORD_WIDTH];

  always_comb
    begin
      if (is_tile)
        begin
          out_addr_o = NET_ADDR_WIDTH'(cmd_addr_i[2+:TILE_EPA_WIDTH]);
          out_x_o    = cmd_addr_i[2+TILE_EPA_WIDTH+:X_CORD_WIDTH];
          out_y_o    = cmd_addr_i[2+TILE_EPA_WIDTH+X_CORD_WIDTH+:Y_CORD_WIDTH];
        end
      else if (is_vcache)
        begin
          out_addr_o = cmd_addr_i[2+:NET_ADDR_WIDTH];
          out_x_o    = cmd_addr_i[2+NET_ADDR_WIDTH+:X_CORD_WIDTH];
          out_y_o    = vcache_top_row ? '1 : '0;
        end
      else
        begin
          // host sits one row above this endpoint
          out_addr_o = cmd_addr_i[0+:NET_ADDR_WIDTH];
          out_x_o    = '0;
          out_y_o    = my_y_i - Y_CORD_WIDTH'(1);
        end
    end

  ////////////////////////////////////////////////////////////////////////////
  // opcode, payload and mask
  ////////////////////////////////////////////////////////////////////////////

  logic [MASK_WIDTH-1:0] store_mask;

  always_comb
    begin
      case (cmd_size_i)
        e_size_1: store_mask = 4'h1 << cmd_addr_i[1:0];
        e_size_2: store_mask = 4'h3 << cmd_addr_i[1:0];
        default:  store_mask = 4'hf << cmd_addr_i[1:0];
      endcase
    end

  always_comb
    begin
      out_op_o      = e_remote_store;
      out_payload_o = cmd_data_i;
      out_mask_o    = '0;
      case (cmd_msg_i)
        e_mem_rd, e_mem_uc_rd:
          begin
            // part select plus the hex and byte op flags
            out_op_o           = e_remote_load;
            out_payload_o      = '0;
            out_payload_o[1:0] = cmd_addr_i[1:0];
            out_payload_o[2]   = (cmd_size_i == e_size_2);
            out_payload_o[3]   = (cmd_size_i == e_size_1);
          end
        e_mem_amo:
          begin
            case (cmd_subop_i)
              e_amoadd: out_op_o = e_remote_amoadd;
              e_amoor:  out_op_o = e_remote_amoor;
              default:  out_op_o = e_remote_amoswap;
            endcase
          end
        default:
          begin
            // wr and uc_wr
            out_mask_o = store_mask;
          end
      endcase
    end

  assign out_reg_id_o = {{(REG_ID_WIDTH-TRANS_ID_WIDTH){1'b0}}, alloc_id_i};

  // issue needs a command, a free id and a ready network
  assign out_v_o   = cmd_v_i & alloc_v_i & out_ready_i;
  assign alloc_o   = out_v_o;
  assign cmd_pop_o = out_v_o;

endmodule

/* rtl/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo
  import mc_bridge_pkg::*;
  (input                            clk_i
   , input                          reset_i

   , input [PADDR_WIDTH-1:0]        wr_addr_i
   , input mem_msg_e                wr_msg_i
   , input msg_size_e               wr_size_i
   , input amo_subop_e              wr_subop_i
   , input [DATA_WIDTH-1:0]         wr_data_i
   , input                          wr_v_i
   , output logic                   wr_ready_o

   , output logic [PADDR_WIDTH-1:0] head_addr_o
   , output mem_msg_e               head_msg_o
   , output msg_size_e              head_size_o
   , output amo_subop_e             head_subop_o
   , output logic [DATA_WIDTH-1:0]  head_data_o
   , output logic                   head_v_o
   , input                          pop_i
   );

  // two entries need only one-bit pointers
  logic [PADDR_WIDTH-1:0] addr_mem  [2];
  mem_msg_e               msg_mem   [2];
  msg_size_e              size_mem  [2];
  amo_subop_e             subop_mem [2];
  logic [DATA_WIDTH-1:0]  data_mem  [2];

  logic       wr_ptr_r, rd_ptr_r;
  logic [1:0] count_r;
  logic       push, pop;

  assign wr_ready_o = (count_r != 2'd2);
  assign head_v_o   = (count_r != 2'd0);

  assign push = wr_v_i & wr_ready_o;
  assign pop  = pop_i & head_v_o;

  always_ff @(posedge clk_i)
    begin
      if (push)
        begin
          addr_mem[wr_ptr_r]  <= wr_addr_i;
          msg_mem[wr_ptr_r]   <= wr_msg_i;
          size_mem[wr_ptr_r]  <= wr_size_i;
          subop_mem[wr_ptr_r] <= wr_subop_i;
          data_mem[wr_ptr_r]  <= wr_data_i;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          wr_ptr_r <= 1'b0;
          rd_ptr_r <= 1'b0;
          count_r  <= 2'd0;
        end
      else
        begin
          if (push)
            wr_ptr_r <= ~wr_ptr_r;
          if (pop)
            rd_ptr_r <= ~rd_ptr_r;
          // count only moves when exactly one side fires
          case ({push, pop})
            2'b10:   count_r <= count_r + 2'd1;
            2'b01:   count_r <= count_r - 2'd1;
            default: count_r <= count_r;
          endcase
        end
    end

  // oldest command
  assign head_addr_o  = addr_mem[rd_ptr_r];
  assign head_msg_o   = msg_mem[rd_ptr_r];
  assign head_size_o  = size_mem[rd_ptr_r];
  assign head_subop_o = subop_mem[rd_ptr_r];
  assign head_data_o  = data_mem[rd_ptr_r];

endmodule

/* rtl/mc_bridge_pkg.sv */
package mc_bridge_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // processor side
  localparam int PADDR_WIDTH = 40;
  localparam int DATA_WIDTH  = 32;
  localparam int MASK_WIDTH  = DATA_WIDTH / 8;

  // mesh endpoint side
  localparam int NET_ADDR_WIDTH = 28;
  localparam int X_CORD_WIDTH   = 7;
  localparam int Y_CORD_WIDTH   = 7;

  // one id per outstanding transaction
  localparam int MAX_OUTSTANDING = 4;
  localparam int TRANS_ID_WIDTH  = $clog2(MAX_OUTSTANDING);
  localparam int REG_ID_WIDTH    = 5;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // word address span inside one compute tile
  localparam int TILE_EPA_WIDTH = 18;

  // top two bits of the physical address pick the target
  localparam logic [1:0] TARGET_TILE   = 2'b11;
  localparam logic [1:0] TARGET_VCACHE = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0]
  {
    e_mem_rd    = 3'b000
    , e_mem_wr    = 3'b001
    , e_mem_uc_rd = 3'b010
    , e_mem_uc_wr = 3'b011
    , e_mem_amo   = 3'b100
  } mem_msg_e;

  // log2 of the access size in bytes
  typedef enum logic [1:0]
  {
    e_size_1   = 2'b00
    , e_size_2 = 2'b01
    , e_size_4 = 2'b10
  } msg_size_e;

  typedef enum logic [1:0]
  {
    e_amoadd    = 2'b00
    , e_amoor   = 2'b01
    , e_amoswap = 2'b10
  } amo_subop_e;

  // same numbering as the mesh packet op field
  typedef enum logic [2:0]
  {
    e_remote_load      = 3'd0
    , e_remote_store   = 3'd1
    , e_remote_amoswap = 3'd4
    , e_remote_amoor   = 3'd5
    , e_remote_amoadd  = 3'd6
  } net_op_e;

endpackage
